//--- dcache_pkg.sv
package dcache_pkg;

    // geometry of one cache line
    localparam int unsigned ADDR_W     = 32;  // address and data word
    localparam int unsigned LINE_WORDS = 8;   // also the bank count
    localparam int unsigned OFFSET_W   = 5;
    localparam int unsigned LINE_W     = 256; // memory bus line width
    localparam int unsigned NUM_WAYS   = 2;

    // word select inside a line from address bits 4 to 2
    localparam int unsigned WORD_OFF_W = OFFSET_W - 2;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } mem_op_e;

    typedef enum logic [2:0] {
        ST_IDLE       = 3'd0,
        ST_LOOKUP     = 3'd1,
        ST_WRITEBACK  = 3'd2, // dirty victim out
        ST_REFILL     = 3'd3, // line request and wait for return
        ST_FILL_WRITE = 3'd4
    } cache_state_e;

endpackage

//--- dcache_bank.sv
`timescale 1ns/100ps

module dcache_bank import dcache_pkg::*; #(
    parameter int unsigned INDEX_W = 7
) (
    input  logic               clk,
    input  logic [INDEX_W-1:0] read_index_i,
    input  logic [INDEX_W-1:0] write_index_i,
    input  logic [3:0]         be_way0_i,
    input  logic [3:0]         be_way1_i,
    input  logic [ADDR_W-1:0]  wdata_i,
    output logic [ADDR_W-1:0]  rdata_way0_o,
    output logic [ADDR_W-1:0]  rdata_way1_o
);

    localparam int unsigned SETS = 1 << INDEX_W;

    // one word of every line, per way
    logic [ADDR_W-1:0] way0_mem [SETS];
    logic [ADDR_W-1:0] way1_mem [SETS];

    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (be_way0_i[b]) way0_mem[write_index_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
            if (be_way1_i[b]) way1_mem[write_index_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
    end

    always_ff @(posedge clk) begin
        rdata_way0_o <= way0_mem[read_index_i];
        rdata_way1_o <= way1_mem[read_index_i];
    end

endmodule

//--- dcache_tag_array.sv
`timescale 1ns/100ps

module dcache_tag_array import dcache_pkg::*; #(
    parameter int unsigned INDEX_W = 7,
    localparam int unsigned TAG_W  = ADDR_W - INDEX_W - OFFSET_W
) (
    input  logic                clk,
    input  logic                reset,
    input  logic [INDEX_W-1:0]  read_index_i,
    input  logic [INDEX_W-1:0]  write_index_i,
    input  logic [NUM_WAYS-1:0] tag_we_i,
    input  logic [TAG_W-1:0]    tag_wdata_i,
    input  logic [TAG_W-1:0]    lookup_tag_i,
    output logic                hit_way0_o,
    output logic                hit_way1_o,
    output logic [TAG_W-1:0]    victim_tag0_o,
    output logic [TAG_W-1:0]    victim_tag1_o
);

    localparam int unsigned SETS = 1 << INDEX_W;

    logic [TAG_W-1:0]              tag_mem [NUM_WAYS][SETS];
    logic [SETS-1:0][NUM_WAYS-1:0] valid_q;
    logic [TAG_W-1:0]              rd_tag_q [NUM_WAYS];
    logic [NUM_WAYS-1:0]           rd_valid_q;

    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (tag_we_i[w]) tag_mem[w][write_index_i] <= tag_wdata_i;
            rd_tag_q[w] <= tag_mem[w][read_index_i]; // old value on same-set write
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q    <= '0;
            rd_valid_q <= '0;
        end else begin
            rd_valid_q <= valid_q[read_index_i];
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (tag_we_i[w]) valid_q[write_index_i][w] <= 1'b1;
            end
        end
    end

    assign hit_way0_o    = rd_valid_q[0] && (rd_tag_q[0] == lookup_tag_i);
    assign hit_way1_o    = rd_valid_q[1] && (rd_tag_q[1] == lookup_tag_i);
    assign victim_tag0_o = rd_tag_q[0];
    assign victim_tag1_o = rd_tag_q[1];

endmodule

//--- dcache_word_sel.sv
`timescale 1ns/100ps

module dcache_word_sel import dcache_pkg::*; (
    input  logic [LINE_WORDS-1:0][ADDR_W-1:0] way0_words_i,
    input  logic [LINE_WORDS-1:0][ADDR_W-1:0] way1_words_i,
    input  logic                              sel_way_i,
    input  logic                              victim_way_i,
    input  logic [WORD_OFF_W-1:0]             word_off_i,
    output logic [ADDR_W-1:0]                 load_word_o,
    output logic [LINE_W-1:0]                 victim_line_o
);

    logic [ADDR_W-1:0] way0_word;
    logic [ADDR_W-1:0] way1_word;

    assign way0_word   = way0_words_i[word_off_i];
    assign way1_word   = way1_words_i[word_off_i];
    assign load_word_o = sel_way_i ? way1_word : way0_word;

    // word 0 in the low bits as in the refill line
    always_comb begin
        for (int i = 0; i < LINE_WORDS; i++) begin
            victim_line_o[i*ADDR_W +: ADDR_W] = victim_way_i ? way1_words_i[i] : way0_words_i[i];
        end
    end

endmodule

//--- dcache_ctrl.sv
`timescale 1ns/100ps

module dcache_ctrl import dcache_pkg::*; #(
    parameter int unsigned INDEX_W = 7,
    localparam int unsigned TAG_W  = ADDR_W - INDEX_W - OFFSET_W
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               req_valid_i,
    input  mem_op_e                            req_op_i,
    input  logic [ADDR_W-1:0]                  req_addr_i,
    input  logic [3:0]                         req_wstrb_i,
    input  logic [ADDR_W-1:0]                  req_wdata_i,
    output logic                               addr_ok_o,
    output logic                               data_ok_o,
    output logic                               cache_miss_o,
    input  logic                               hit_way0_i,
    input  logic                               hit_way1_i,
    input  logic [TAG_W-1:0]                   victim_tag0_i,
    input  logic [TAG_W-1:0]                   victim_tag1_i,
    input  logic [ADDR_W-1:0]                  load_word_i,
    input  logic                               ret_valid_i,
    input  logic [LINE_W-1:0]                  ret_data_i,
    input  logic                               rd_rdy_i,
    input  logic                               wr_rdy_i,
    output logic                               rd_req_o,
    output logic [ADDR_W-1:0]                  rd_addr_o,
    output logic                               wr_req_o,
    output logic [ADDR_W-1:0]                  wr_addr_o,
    output logic [INDEX_W-1:0]                 read_index_o,
    output logic [INDEX_W-1:0]                 write_index_o,
    output logic [NUM_WAYS-1:0]                tag_we_o,
    output logic [TAG_W-1:0]                   tag_wdata_o,
    output logic [LINE_WORDS-1:0][3:0]         bank_be_way0_o,
    output logic [LINE_WORDS-1:0][3:0]         bank_be_way1_o,
    output logic [LINE_WORDS-1:0][ADDR_W-1:0]  bank_wdata_o,
    output logic                               sel_way_o,
    output logic                               victim_way_o,
    output logic [WORD_OFF_W-1:0]              word_off_o,
    output logic [ADDR_W-1:0]                  rdata_o
);

    localparam int unsigned SETS = 1 << INDEX_W;

    cache_state_e state_q;
    cache_state_e state_d;

    // request stage
    mem_op_e           op_q;
    logic [ADDR_W-1:0] addr_q;
    logic [3:0]        wstrb_q;
    logic [ADDR_W-1:0] wdata_q;

    logic [SETS-1:0]                 lru_q; // way to replace next
    logic [SETS-1:0][NUM_WAYS-1:0]   dirty_q;
    logic                            rd_sent_q;
    logic [LINE_WORDS-1:0][ADDR_W-1:0] fill_line_q;

    logic [INDEX_W-1:0]    idx;
    logic [WORD_OFF_W-1:0] off;
    logic                  hit;
    logic                  hit_store;
    logic                  accept;
    logic                  victim;
    logic                  refill_done;
    logic [TAG_W-1:0]      victim_tag;
    logic [ADDR_W-1:0]     wmask;
    logic [ADDR_W-1:0]     ret_word;

    assign idx        = addr_q[OFFSET_W +: INDEX_W];
    assign off        = addr_q[2 +: WORD_OFF_W];
    assign hit        = (state_q == ST_LOOKUP) && (hit_way0_i || hit_way1_i);
    assign hit_store  = hit && (op_q == OP_WRITE);
    assign victim     = lru_q[idx];
    assign victim_tag = victim ? victim_tag1_i : victim_tag0_i;
    assign wmask      = {{8{wstrb_q[3]}}, {8{wstrb_q[2]}}, {8{wstrb_q[1]}}, {8{wstrb_q[0]}}};
    assign ret_word   = ret_data_i[off*ADDR_W +: ADDR_W];
    assign refill_done = (state_q == ST_REFILL) && rd_sent_q && ret_valid_i;

    // a store hit blocks the next accept for one cycle
    assign addr_ok_o    = (state_q == ST_IDLE) || (hit && op_q == OP_READ);
    assign accept       = req_valid_i && addr_ok_o;
    assign data_ok_o    = hit || (state_q == ST_FILL_WRITE);
    assign cache_miss_o = (state_q == ST_LOOKUP) ? !hit : (state_q != ST_IDLE);

    assign rd_req_o  = (state_q == ST_REFILL) && !rd_sent_q;
    assign rd_addr_o = {addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    assign wr_req_o  = (state_q == ST_WRITEBACK);
    assign wr_addr_o = {victim_tag, idx, {OFFSET_W{1'b0}}};

    assign read_index_o  = accept ? req_addr_i[OFFSET_W +: INDEX_W] : idx;
    assign write_index_o = idx;
    assign tag_wdata_o   = addr_q[ADDR_W-1 -: TAG_W]; // also the lookup tag
    assign sel_way_o     = hit_way1_i;
    assign victim_way_o  = victim;
    assign word_off_o    = off;
    assign rdata_o       = (state_q == ST_FILL_WRITE) ? fill_line_q[off] : load_word_i;

    always_comb begin
        tag_we_o       = '0;
        bank_be_way0_o = '0;
        bank_be_way1_o = '0;
        bank_wdata_o   = fill_line_q;
        if (state_q == ST_FILL_WRITE) begin
            tag_we_o[victim] = 1'b1;
            for (int i = 0; i < LINE_WORDS; i++) begin
                if (victim) bank_be_way1_o[i] = 4'hf;
                else        bank_be_way0_o[i] = 4'hf;
            end
        end else if (hit_store) begin
            bank_wdata_o[off] = wdata_q; // only the addressed bank gets strobes
            if (hit_way1_i) bank_be_way1_o[off] = wstrb_q;
            else            bank_be_way0_o[off] = wstrb_q;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (accept) state_d = ST_LOOKUP;
            end
            ST_LOOKUP: begin
                if (hit) state_d = accept ? ST_LOOKUP : ST_IDLE;
                else if (dirty_q[idx][victim]) state_d = ST_WRITEBACK;
                else state_d = ST_REFILL;
            end
            ST_WRITEBACK: begin
                if (wr_rdy_i) state_d = ST_REFILL;
            end
            ST_REFILL: begin
                if (refill_done) state_d = ST_FILL_WRITE;
            end
            default: state_d = ST_IDLE; // fill write lasts one cycle
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q   <= ST_IDLE;
            rd_sent_q <= 1'b0;
            lru_q     <= '0;
            dirty_q   <= '0;
        end else begin
            state_q <= state_d;
            if (rd_req_o && rd_rdy_i) rd_sent_q <= 1'b1;
            else if (refill_done)     rd_sent_q <= 1'b0;
            if (hit) begin
                lru_q[idx] <= hit_way0_i;
                if (op_q == OP_WRITE) dirty_q[idx][hit_way1_i] <= 1'b1;
            end else if (state_q == ST_FILL_WRITE) begin
                lru_q[idx]           <= ~victim;
                dirty_q[idx][victim] <= (op_q == OP_WRITE);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q    <= req_op_i;
            addr_q  <= req_addr_i;
            wstrb_q <= req_wstrb_i;
            wdata_q <= req_wdata_i;
        end
        if (refill_done) begin
            for (int i = 0; i < LINE_WORDS; i++) begin
                fill_line_q[i] <= ret_data_i[i*ADDR_W +: ADDR_W];
            end
            if (op_q == OP_WRITE) fill_line_q[off] <= (wdata_q & wmask) | (ret_word & ~wmask);
        end
    end

endmodule

//--- dcache_top.sv
`timescale 1ns/100ps

module dcache_top import dcache_pkg::*; #(
    parameter int unsigned INDEX_W = 7
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              req_valid_i,
    input  mem_op_e           req_op_i,
    input  logic [ADDR_W-1:0] req_addr_i,
    input  logic [3:0]        req_wstrb_i,
    input  logic [ADDR_W-1:0] req_wdata_i,
    output logic              addr_ok_o,
    output logic              data_ok_o,
    output logic [ADDR_W-1:0] rdata_o,
    output logic              cache_miss_o,
    output logic              rd_req_o,
    output logic [ADDR_W-1:0] rd_addr_o,
    input  logic              rd_rdy_i,
    input  logic              ret_valid_i,
    input  logic [LINE_W-1:0] ret_data_i,
    output logic              wr_req_o,
    output logic [ADDR_W-1:0] wr_addr_o,
    output logic [LINE_W-1:0] wr_data_o,
    input  logic              wr_rdy_i
);

    localparam int unsigned TAG_W = ADDR_W - INDEX_W - OFFSET_W;

    logic                              hit_way0;
    logic                              hit_way1;
    logic [TAG_W-1:0]                  victim_tag0;
    logic [TAG_W-1:0]                  victim_tag1;
    logic [TAG_W-1:0]                  tag_wdata;
    logic [NUM_WAYS-1:0]               tag_we;
    logic [INDEX_W-1:0]                read_index;
    logic [INDEX_W-1:0]                write_index;
    logic [LINE_WORDS-1:0][3:0]        bank_be_way0;
    logic [LINE_WORDS-1:0][3:0]        bank_be_way1;
    logic [LINE_WORDS-1:0][ADDR_W-1:0] bank_wdata;
    logic [LINE_WORDS-1:0][ADDR_W-1:0] way0_words;
    logic [LINE_WORDS-1:0][ADDR_W-1:0] way1_words;
    logic [ADDR_W-1:0]                 load_word;
    logic                              sel_way;
    logic                              victim_way;
    logic [WORD_OFF_W-1:0]             word_off;

    dcache_ctrl #(.INDEX_W(INDEX_W)) i_dcache_ctrl (
        .clk            (clk),
        .reset          (reset),
        .req_valid_i    (req_valid_i),
        .req_op_i       (req_op_i),
        .req_addr_i     (req_addr_i),
        .req_wstrb_i    (req_wstrb_i),
        .req_wdata_i    (req_wdata_i),
        .addr_ok_o      (addr_ok_o),
        .data_ok_o      (data_ok_o),
        .cache_miss_o   (cache_miss_o),
        .hit_way0_i     (hit_way0),
        .hit_way1_i     (hit_way1),
        .victim_tag0_i  (victim_tag0),
        .victim_tag1_i  (victim_tag1),
        .load_word_i    (load_word),
        .ret_valid_i    (ret_valid_i),
        .ret_data_i     (ret_data_i),
        .rd_rdy_i       (rd_rdy_i),
        .wr_rdy_i       (wr_rdy_i),
        .rd_req_o       (rd_req_o),
        .rd_addr_o      (rd_addr_o),
        .wr_req_o       (wr_req_o),
        .wr_addr_o      (wr_addr_o),
        .read_index_o   (read_index),
        .write_index_o  (write_index),
        .tag_we_o       (tag_we),
        .tag_wdata_o    (tag_wdata),
        .bank_be_way0_o (bank_be_way0),
        .bank_be_way1_o (bank_be_way1),
        .bank_wdata_o   (bank_wdata),
        .sel_way_o      (sel_way),
        .victim_way_o   (victim_way),
        .word_off_o     (word_off),
        .rdata_o        (rdata_o)
    );

    // the write tag is the request tag, so it doubles as the lookup tag
    dcache_tag_array #(.INDEX_W(INDEX_W)) i_dcache_tag_array (
        .clk           (clk),
        .reset         (reset),
        .read_index_i  (read_index),
        .write_index_i (write_index),
        .tag_we_i      (tag_we),
        .tag_wdata_i   (tag_wdata),
        .lookup_tag_i  (tag_wdata),
        .hit_way0_o    (hit_way0),
        .hit_way1_o    (hit_way1),
        .victim_tag0_o (victim_tag0),
        .victim_tag1_o (victim_tag1)
    );

    for (genvar i = 0; i < LINE_WORDS; i++) begin : g_bank
        dcache_bank #(.INDEX_W(INDEX_W)) i_dcache_bank (
            .clk           (clk),
            .read_index_i  (read_index),
            .write_index_i (write_index),
            .be_way0_i     (bank_be_way0[i]),
            .be_way1_i     (bank_be_way1[i]),
            .wdata_i       (bank_wdata[i]),
            .rdata_way0_o  (way0_words[i]),
            .rdata_way1_o  (way1_words[i])
        );
    end

    dcache_word_sel i_dcache_word_sel (
        .way0_words_i  (way0_words),
        .way1_words_i  (way1_words),
        .sel_way_i     (sel_way),
        .victim_way_i  (victim_way),
        .word_off_i    (word_off),
        .load_word_o   (load_word),
        .victim_line_o (wr_data_o)
    );

endmodule

//--- dcache_checker.sv
`timescale 1ns/100ps

module dcache_checker import dcache_pkg::*; (
    input logic              clk,
    input logic              reset,
    input logic              req_valid_i,
    input logic              addr_ok_i,
    input logic              data_ok_i,
    input logic              rd_req_i,
    input logic              rd_rdy_i,
    input logic [ADDR_W-1:0] rd_addr_i,
    input logic              wr_req_i,
    input logic              wr_rdy_i,
    input logic [ADDR_W-1:0] wr_addr_i,
    input logic [LINE_W-1:0] wr_data_i
);

    int unsigned pending_q; // accepted requests still waiting for data_ok

    always_ff @(posedge clk) begin
        if (reset) begin
            pending_q <= 0;
        end else begin
            pending_q <= pending_q + int'(req_valid_i && addr_ok_i) - int'(data_ok_i);
        end
    end

    a_no_dual_req : assert property (@(posedge clk) disable iff (reset)
        !(rd_req_i && wr_req_i))
        else $error("rd_req_o and wr_req_o high together");

    a_rd_hold : assert property (@(posedge clk) disable iff (reset)
        rd_req_i && !rd_rdy_i |=> rd_req_i && $stable(rd_addr_i))
        else $error("read request dropped or changed while stalled");

    a_wr_hold : assert property (@(posedge clk) disable iff (reset)
        wr_req_i && !wr_rdy_i |=> wr_req_i && $stable(wr_addr_i) && $stable(wr_data_i))
        else $error("write request dropped or changed while stalled");

    a_data_ok_owed : assert property (@(posedge clk) disable iff (reset)
        data_ok_i |-> pending_q != 0)
        else $error("data_ok_o without an outstanding request");

endmodule

bind dcache_top dcache_checker i_dcache_checker (
    .clk         (clk),
    .reset       (reset),
    .req_valid_i (req_valid_i),
    .addr_ok_i   (addr_ok_o),
    .data_ok_i   (data_ok_o),
    .rd_req_i    (rd_req_o),
    .rd_rdy_i    (rd_rdy_i),
    .rd_addr_i   (rd_addr_o),
    .wr_req_i    (wr_req_o),
    .wr_rdy_i    (wr_rdy_i),
    .wr_addr_i   (wr_addr_o),
    .wr_data_i   (wr_data_o)
);

//--- tb_dcache.sv
`timescale 1ns/100ps

module tb_dcache;
    import dcache_pkg::*;

    localparam int unsigned INDEX_W = 2; // four sets so evictions come quickly
    localparam int unsigned PERIOD  = 40;

    logic              clk;
    logic              reset;
    logic              req_valid_i;
    mem_op_e           req_op_i;
    logic [ADDR_W-1:0] req_addr_i;
    logic [3:0]        req_wstrb_i;
    logic [ADDR_W-1:0] req_wdata_i;
    logic              addr_ok_o;
    logic              data_ok_o;
    logic [ADDR_W-1:0] rdata_o;
    logic              cache_miss_o;
    logic              rd_req_o;
    logic [ADDR_W-1:0] rd_addr_o;
    logic              rd_rdy_i;
    logic              ret_valid_i;
    logic [LINE_W-1:0] ret_data_i;
    logic              wr_req_o;
    logic [ADDR_W-1:0] wr_addr_o;
    logic [LINE_W-1:0] wr_data_o;
    logic              wr_rdy_i;

    logic [31:0] g_op[$];
    logic [31:0] g_addr[$];
    logic [31:0] g_strb[$];
    logic [31:0] g_wdata[$];
    logic [31:0] g_rdata[$];
    logic [31:0] g_miss[$];
    int          n_req = 0;
    int          err_cnt = 0;
    int          pass_cnt = 0;
    int          data_ok_cnt = 0;
    bit          loaded = 0;

    logic [31:0] mem[int unsigned];    // words written back by the cache
    logic [31:0] shadow[int unsigned]; // what the CPU expects to read
    logic [15:0] lfsr = 16'd9884;
    int          ret_cnt = 0;
    logic [31:0] ret_addr;
    logic [31:0] cur_addr;
    logic        rd_hs = 0;
    logic        wr_hs = 0;
    logic [31:0] wr_addr_s;
    logic [LINE_W-1:0] wr_data_s;

    dcache_top #(.INDEX_W(INDEX_W)) i_dcache_top (.*);

    always #(PERIOD/2) clk = ~clk;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return mem.exists(a) ? mem[a] : (a ^ 32'h5a5a0000);
    endfunction

    function automatic logic [31:0] shadow_word(input logic [31:0] a);
        return shadow.exists(a) ? shadow[a] : (a ^ 32'h5a5a0000);
    endfunction

    function automatic logic [LINE_W-1:0] read_line(input logic [31:0] base);
        logic [LINE_W-1:0] l;
        for (int i = 0; i < LINE_WORDS; i++) l[i*32 +: 32] = mem_word(base + 4*i);
        return l;
    endfunction

    // handshakes seen mid-cycle take effect at the next rising edge
    always @(negedge clk) begin
        rd_hs = !reset && rd_req_o && rd_rdy_i;
        wr_hs = !reset && wr_req_o && wr_rdy_i;
        if (!reset && data_ok_o) data_ok_cnt++;
        if (rd_hs) begin
            ret_addr = rd_addr_o;
            if (rd_addr_o !== {cur_addr[31:5], 5'b00000}) begin
                $display("error rd_addr_o: got %h expected %h", rd_addr_o,
                         {cur_addr[31:5], 5'b00000});
                err_cnt++;
            end
        end
        if (wr_hs) begin
            wr_addr_s = wr_addr_o;
            wr_data_s = wr_data_o;
            if (wr_addr_o[4:0] != 0) begin
                $display("error wr_addr_o: got %h, not line aligned", wr_addr_o);
                err_cnt++;
            end
            for (int i = 0; i < LINE_WORDS; i++) begin
                if (wr_data_o[i*32 +: 32] !== shadow_word(wr_addr_o + 4*i)) begin
                    $display("error wr_data_o word %0d: got %h expected %h", i,
                             wr_data_o[i*32 +: 32], shadow_word(wr_addr_o + 4*i));
                    err_cnt++;
                end
            end
        end
    end

    // memory model
    always @(posedge clk) begin
        if (reset) begin
            rd_rdy_i    <= 1'b0;
            wr_rdy_i    <= 1'b0;
            ret_valid_i <= 1'b0;
            ret_cnt = 0;
        end else begin
            lfsr = lfsr_next(lfsr);
            rd_rdy_i <= lfsr[0];
            lfsr = lfsr_next(lfsr);
            wr_rdy_i <= lfsr[0];
            ret_valid_i <= 1'b0;
            if (ret_cnt != 0) begin
                ret_cnt--;
                if (ret_cnt == 0) begin
                    ret_valid_i <= 1'b1;
                    ret_data_i  <= read_line(ret_addr);
                end
            end
            if (rd_hs) begin
                lfsr = lfsr_next(lfsr);
                ret_cnt = lfsr[0];
                lfsr = lfsr_next(lfsr);
                ret_cnt = ret_cnt + 2*lfsr[0] + 1; // 1 to 4 cycles
            end
            if (wr_hs) begin
                for (int i = 0; i < LINE_WORDS; i++) mem[wr_addr_s + 4*i] = wr_data_s[i*32 +: 32];
            end
        end
    end

    task automatic run_test(input int t);
        logic [31:0] got;
        logic [31:0] old;
        logic        miss;
        bit          saw_rd;
        int          errs0;
        errs0    = err_cnt;
        saw_rd   = 0;
        cur_addr = g_addr[t];
        @(posedge clk);
        req_valid_i <= 1'b1;
        req_op_i    <= mem_op_e'(g_op[t][0]);
        req_addr_i  <= g_addr[t];
        req_wstrb_i <= g_strb[t][3:0];
        req_wdata_i <= g_wdata[t];
        do @(negedge clk); while (!addr_ok_o);
        if (g_op[t][0]) begin
            old = shadow_word({g_addr[t][31:2], 2'b00});
            for (int b = 0; b < 4; b++) begin
                if (g_strb[t][b]) old[b*8 +: 8] = g_wdata[t][b*8 +: 8];
            end
            shadow[{g_addr[t][31:2], 2'b00}] = old;
        end
        @(posedge clk);
        req_valid_i <= 1'b0;
        do begin
            @(negedge clk);
            if (rd_req_o) saw_rd = 1;
        end while (!data_ok_o);
        got  = rdata_o;
        miss = cache_miss_o;
        if (!g_op[t][0] && got !== g_rdata[t]) begin
            $display("error rdata_o: got %h expected %h", got, g_rdata[t]);
            err_cnt++;
        end
        if (miss !== g_miss[t][0]) begin
            $display("error cache_miss_o: got %h expected %h", miss, g_miss[t][0]);
            err_cnt++;
        end
        if (!g_miss[t][0] && saw_rd) begin
            $display("a line read was requested during a hit");
            err_cnt++;
        end
        if (g_miss[t][0] && !saw_rd) begin
            $display("a miss completed without a line read");
            err_cnt++;
        end
        if (err_cnt == errs0) pass_cnt++;
        $display("test %0d addr %h: %s", t, g_addr[t], (err_cnt == errs0) ? "ok" : "wrong");
    endtask

    initial begin
        int    fd;
        string line;
        logic [31:0] f0, f1, f2, f3, f4, f5;
        clk         = 1'b0;
        reset       = 1'b1;
        req_valid_i = 1'b0;
        req_op_i    = OP_READ;
        req_addr_i  = '0;
        req_wstrb_i = '0;
        req_wdata_i = '0;
        rd_rdy_i    = 1'b0;
        wr_rdy_i    = 1'b0;
        ret_valid_i = 1'b0;
        ret_data_i  = '0;
        cur_addr    = '0;
        fd = $fopen("dcache_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open dcache_golden.txt");
            err_cnt++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() == 0 || line[0] == "#") continue;
                if ($sscanf(line, "%h %h %h %h %h %h", f0, f1, f2, f3, f4, f5) == 6) begin
                    g_op.push_back(f0);
                    g_addr.push_back(f1);
                    g_strb.push_back(f2);
                    g_wdata.push_back(f3);
                    g_rdata.push_back(f4);
                    g_miss.push_back(f5);
                end
            end
            $fclose(fd);
        end
        n_req  = g_op.size();
        loaded = 1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        for (int t = 0; t < n_req; t++) run_test(t);
        repeat (4) @(posedge clk);
        if (data_ok_cnt != n_req) begin
            $display("saw %0d data_ok pulses for %0d requests", data_ok_cnt, n_req);
            err_cnt++;
        end
        $display("%0d tests, %0d passed, %0d errors", n_req, pass_cnt, err_cnt);
        if (err_cnt == 0 && n_req > 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (loaded);
        #((n_req + 2) * 40 * PERIOD);
        $display("timeout, requests did not complete in time");
        $display("Test failed");
        $finish;
    end

endmodule

//--- dcache_golden.txt
# op(0 load, 1 store) addr wstrb wdata expected_load_data expected_miss
# four sets of two ways, lines 0x000 0x080 0x100 0x200 0x300 0x380 share set 0
0 00000004 0 00000000 5a5a0004 1
0 00000004 0 00000000 5a5a0004 0
1 00000008 3 0000beef 00000000 0
0 00000008 0 00000000 5a5abeef 0
1 0000000c c 12340000 00000000 0
0 0000000c 0 00000000 1234000c 0
0 00000080 0 00000000 5a5a0080 1
0 00000000 0 00000000 5a5a0000 0
0 00000100 0 00000000 5a5a0100 1
0 00000008 0 00000000 5a5abeef 0
0 00000084 0 00000000 5a5a0084 1
0 00000104 0 00000000 5a5a0104 1
0 00000008 0 00000000 5a5abeef 1
0 0000000c 0 00000000 1234000c 0
1 00000214 1 000000a5 00000000 1
0 00000214 0 00000000 5a5a02a5 0
0 00000300 0 00000000 5a5a0300 1
0 00000380 0 00000000 5a5a0380 1
0 00000214 0 00000000 5a5a02a5 1
0 0000000c 0 00000000 1234000c 1
1 00000020 f cafef00d 00000000 1
0 00000020 0 00000000 cafef00d 0
1 00000024 6 00ff3300 00000000 0
0 00000024 0 00000000 5aff3324 0
0 00000060 0 00000000 5a5a0060 1

//--- vlog.f
dcache_pkg.sv
dcache_bank.sv
dcache_tag_array.sv
dcache_word_sel.sv
dcache_ctrl.sv
dcache_top.sv
dcache_checker.sv
tb_dcache.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
TOP       ?= tb_dcache
FILELIST  ?= vlog.f
PASS_MSG  := Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
